//--- src/pcxt_pkg.sv
// timing counts are shortened for simulation; scale splash and power hold before use on hardware
package pcxt_pkg;

	////////////////////////////////
	// status word layout
	////////////////////////////////
	localparam int status_w = 32;
	localparam int stat_tandy = 3;
	localparam int stat_mda = 4;
	localparam int stat_splash = 7;
	localparam int stat_speed_lo = 17;
	localparam int stat_speed_hi = 18;

	// cpu speed codes in the osd menu encoding
	typedef enum logic [1:0] {
		speed_477  = 2'b00,
		speed_716  = 2'b01,
		speed_1431 = 2'b10
	} speed_t;

	// configuration fields taken from status
	typedef struct packed {
		speed_t speed;
		logic   tandy_req;
		logic   mda_mode;
		logic   splash_skip;
	} cfg_t;

	////////////////////////////////
	// enable generation
	////////////////////////////////
	localparam int phase_len = 12;
	localparam int phase_w = 4;
	localparam int div_477 = 6;
	localparam int div_716 = 4;
	localparam int div_1431 = 2;
	localparam int div_periph = 12;

	////////////////////////////////
	// reset sequence and led
	////////////////////////////////
	localparam int power_hold_cycles = 1024;
	localparam int power_w = 10;
	localparam int cpu_reset_delay = 42;
	localparam int cpu_delay_w = 6;
	localparam int splash_tick_cycles = 256;
	localparam int splash_tick_w = 8;
	localparam int splash_ticks = 5;
	localparam int splash_cnt_w = 3;
	localparam int led_hold_cycles = 1000;
	localparam int led_w = 10;

	// dip switch bytes for cga 80 columns and mda
	localparam logic [7:0] dip_cga = 8'b0010_1101;
	localparam logic [7:0] dip_mda = 8'b0011_1101;

	// audio widths
	localparam int mix_w = 17;
	localparam int dac_w = 16;

endpackage

//--- src/clock_enable_gen.sv
// single clock domain; enables are one-cycle pulses, speed code 2'b11 runs at the slow rate
module clock_enable_gen (
	input  logic             clk_chipset,
	input  logic             reset_wire,
	input  pcxt_pkg::speed_t speed_req,
	input  logic             biu_done,
	input  logic             opl2_clk,
	output logic             cpu_ce,
	output logic             periph_ce,
	output logic             opl2_ce
);

	localparam int pw = pcxt_pkg::phase_w;

	logic [pw-1:0] phase;
	pcxt_pkg::speed_t speed_act;
	logic cpu_hit;
	logic periph_hit;
	// opl2 clock synchronizer and edge flop
	logic opl2_ff_1;
	logic opl2_ff_2;
	logic opl2_ff_3;

	////////////////////////////////
	// phase counter
	////////////////////////////////
	// one counter stands in for the old divided clock chain
	always_ff @(posedge clk_chipset or posedge reset_wire) begin
		if (reset_wire) begin
			phase <= '0;
		end else if (phase == pw'(pcxt_pkg::phase_len - 1)) begin
			phase <= '0;
		end else begin
			phase <= phase + 1'b1;
		end
	end

	// speed only moves when the bus unit is idle
	always_ff @(posedge clk_chipset or posedge reset_wire) begin
		if (reset_wire) begin
			speed_act <= pcxt_pkg::speed_477;
		end else if (biu_done) begin
			speed_act <= speed_req;
		end
	end

	// phase decode per speed
	always_comb begin
		case (speed_act)
			pcxt_pkg::speed_1431: cpu_hit = (phase % pw'(pcxt_pkg::div_1431)) == '0;
			pcxt_pkg::speed_716:  cpu_hit = (phase % pw'(pcxt_pkg::div_716)) == '0;
			default:              cpu_hit = (phase % pw'(pcxt_pkg::div_477)) == '0;
		endcase
	end

	// peripheral rate at the 2.385 MHz equivalent
	assign periph_hit = (phase % pw'(pcxt_pkg::div_periph)) == '0;

	always_ff @(posedge clk_chipset or posedge reset_wire) begin
		if (reset_wire) begin
			cpu_ce <= 1'b0;
			periph_ce <= 1'b0;
		end else begin
			cpu_ce <= cpu_hit;
			periph_ce <= periph_hit;
		end
	end

	////////////////////////////////
	// opl2 enable
	////////////////////////////////
	// pulse lands three cycles after the external rising edge
	always_ff @(posedge clk_chipset or posedge reset_wire) begin
		if (reset_wire) begin
			opl2_ff_1 <= 1'b0;
			opl2_ff_2 <= 1'b0;
			opl2_ff_3 <= 1'b0;
			opl2_ce <= 1'b0;
		end else begin
			opl2_ff_1 <= opl2_clk;
			opl2_ff_2 <= opl2_ff_1;
			opl2_ff_3 <= opl2_ff_2;
			opl2_ce <= opl2_ff_2 & ~opl2_ff_3;
		end
	end

endmodule

//--- src/reset_sequencer.sv
// splash and power hold are counted in clk_chipset cycles; tandy_mode reads 0 while reset_wire is high
module reset_sequencer (
	input  logic clk_chipset,
	input  logic reset_wire,
	input  logic splash_skip,
	input  logic tandy_req,
	output logic sys_reset,
	output logic cpu_reset,
	output logic tandy_mode
);

	localparam int tw = pcxt_pkg::splash_tick_w;
	localparam int nw = pcxt_pkg::splash_cnt_w;
	localparam int hw = pcxt_pkg::power_w;
	localparam int dw = pcxt_pkg::cpu_delay_w;

	logic splash_on;
	logic [tw-1:0] tick_cnt;
	logic [nw-1:0] tick_num;
	logic [hw-1:0] power_cnt;
	logic cpu_stage;
	logic [dw-1:0] cpu_cnt;

	////////////////////////////////
	// splash and power hold
	////////////////////////////////
	// splash first, then the power-on hold
	always_ff @(posedge clk_chipset or posedge reset_wire) begin
		if (reset_wire) begin
			splash_on <= 1'b1;
			tick_cnt <= '0;
			tick_num <= '0;
			power_cnt <= '0;
			sys_reset <= 1'b1;
		end else if (splash_on) begin
			// skip bit ends the splash at once
			if (splash_skip || tick_num == nw'(pcxt_pkg::splash_ticks)) begin
				splash_on <= 1'b0;
			end else if (tick_cnt == tw'(pcxt_pkg::splash_tick_cycles - 1)) begin
				tick_cnt <= '0;
				tick_num <= tick_num + 1'b1;
			end else begin
				tick_cnt <= tick_cnt + 1'b1;
			end
		end else if (sys_reset) begin
			if (power_cnt == hw'(pcxt_pkg::power_hold_cycles - 1)) begin
				sys_reset <= 1'b0;
			end else begin
				power_cnt <= power_cnt + 1'b1;
			end
		end
	end

	////////////////////////////////
	// cpu reset release
	////////////////////////////////
	// staging flop behind sys_reset
	always_ff @(posedge clk_chipset or posedge reset_wire) begin
		if (reset_wire) begin
			cpu_stage <= 1'b1;
		end else begin
			cpu_stage <= sys_reset;
		end
	end

	// cpu held for cpu_reset_delay more cycles after staging clears
	always_ff @(posedge clk_chipset or posedge reset_wire) begin
		if (reset_wire) begin
			cpu_cnt <= '0;
			cpu_reset <= 1'b1;
		end else if (cpu_stage) begin
			cpu_cnt <= '0;
			cpu_reset <= 1'b1;
		end else if (cpu_cnt != dw'(pcxt_pkg::cpu_reset_delay)) begin
			cpu_cnt <= cpu_cnt + 1'b1;
		end else begin
			cpu_reset <= 1'b0;
		end
	end

	// model bit only sampled during system reset
	always_ff @(posedge clk_chipset or posedge reset_wire) begin
		if (reset_wire) begin
			tandy_mode <= 1'b0;
		end else if (sys_reset) begin
			tandy_mode <= tandy_req;
		end
	end

endmodule

//--- src/audio_mixer_dac.sv
// mixer wraps on overflow, no saturation; dac_sample is two's complement, audio_bit density follows it
module audio_mixer_dac (
	input  logic                              clk_chipset,
	input  logic                              reset_wire,
	input  logic                              speaker,
	input  logic signed [pcxt_pkg::dac_w-1:0] opl2_sample,
	input  logic [7:0]                        tandy_sample,
	output logic [pcxt_pkg::dac_w-1:0]        dac_sample,
	output logic                              audio_bit
);

	localparam int mw = pcxt_pkg::mix_w;
	localparam int sw = pcxt_pkg::dac_w;

	logic [mw-1:0] opl_term;
	logic [mw-1:0] spk_term;
	logic [mw-1:0] tandy_term;
	logic [mw-1:0] mix_sum;
	// sigma-delta accumulator with the carry in its msb
	logic [mw-1:0] acc;
	logic [sw-1:0] dac_offset;

	////////////////////////////////
	// mixer
	////////////////////////////////
	// opl2 sign extended then x4
	assign opl_term = {opl2_sample[sw-1], opl2_sample} << 2;
	// speaker x32768
	assign spk_term = {1'b0, speaker, 15'd0};
	// unsigned tandy x64
	assign tandy_term = {3'b000, tandy_sample, 6'd0};
	assign mix_sum = opl_term + spk_term + tandy_term;

	// half the sum registered one cycle late
	always_ff @(posedge clk_chipset or posedge reset_wire) begin
		if (reset_wire) begin
			dac_sample <= '0;
		end else begin
			dac_sample <= mix_sum[mw-1:1];
		end
	end

	////////////////////////////////
	// first-order modulator
	////////////////////////////////
	// +32768 turns the signed sample into an unsigned level
	assign dac_offset = dac_sample ^ {1'b1, {(sw - 1){1'b0}}};

	always_ff @(posedge clk_chipset or posedge reset_wire) begin
		if (reset_wire) begin
			acc <= '0;
		end else begin
			// drop the last carry and keep the residue
			acc <= {1'b0, acc[sw-1:0]} + {1'b0, dac_offset};
		end
	end

	assign audio_bit = acc[mw-1];

endmodule

//--- src/activity_led.sv
// led is active high; a strobe during the hold restarts the full hold time
module activity_led (
	input  logic clk_chipset,
	input  logic reset_wire,
	input  logic download_strobe,
	output logic led
);

	localparam int lw = pcxt_pkg::led_w;

	logic [lw-1:0] hold_cnt;

	// reload on every strobe, count down to zero
	always_ff @(posedge clk_chipset or posedge reset_wire) begin
		if (reset_wire) begin
			hold_cnt <= '0;
		end else if (download_strobe) begin
			hold_cnt <= lw'(pcxt_pkg::led_hold_cycles);
		end else if (hold_cnt != '0) begin
			hold_cnt <= hold_cnt - 1'b1;
		end
	end

	// lit while any hold time remains
	assign led = hold_cnt != '0;

endmodule

//--- src/pcxt_glue.sv
// status is a static level from the menu; enables and mixer stay idle until sys_reset clears
module pcxt_glue (
	input  logic                                 clk_chipset,
	input  logic                                 reset_wire,
	input  logic [pcxt_pkg::status_w-1:0]        status,
	input  logic                                 biu_done,
	input  logic                                 opl2_clk,
	input  logic                                 port_b_bit3,
	input  logic                                 speaker,
	input  logic signed [pcxt_pkg::dac_w-1:0]    opl2_sample,
	input  logic [7:0]                           tandy_sample,
	input  logic                                 download_strobe,
	output logic                                 cpu_ce,
	output logic                                 periph_ce,
	output logic                                 opl2_ce,
	output logic                                 sys_reset,
	output logic                                 cpu_reset,
	output logic                                 tandy_mode,
	output logic [3:0]                           dip_nibble,
	output logic [pcxt_pkg::dac_w-1:0]           dac_sample,
	output logic                                 audio_bit,
	output logic                                 led
);

	pcxt_pkg::cfg_t cfg;
	logic [7:0] dip_byte;

	////////////////////////////////
	// status decode
	////////////////////////////////
	assign cfg.speed = pcxt_pkg::speed_t'(status[pcxt_pkg::stat_speed_hi:pcxt_pkg::stat_speed_lo]);
	assign cfg.tandy_req = status[pcxt_pkg::stat_tandy];
	assign cfg.mda_mode = status[pcxt_pkg::stat_mda];
	assign cfg.splash_skip = status[pcxt_pkg::stat_splash];

	// port B bit 3 picks the half of the keyboard port C dip byte
	assign dip_byte = cfg.mda_mode ? pcxt_pkg::dip_mda : pcxt_pkg::dip_cga;

	always_ff @(posedge clk_chipset) begin
		dip_nibble <= port_b_bit3 ? dip_byte[7:4] : dip_byte[3:0];
	end

	////////////////////////////////
	// blocks
	////////////////////////////////
	reset_sequencer reset_sequencer_inst (
		.clk_chipset (clk_chipset),
		.reset_wire  (reset_wire),
		.splash_skip (cfg.splash_skip),
		.tandy_req   (cfg.tandy_req),
		.sys_reset   (sys_reset),
		.cpu_reset   (cpu_reset),
		.tandy_mode  (tandy_mode)
	);

	// enables held off by the system reset
	clock_enable_gen clock_enable_gen_inst (
		.clk_chipset (clk_chipset),
		.reset_wire  (sys_reset),
		.speed_req   (cfg.speed),
		.biu_done    (biu_done),
		.opl2_clk    (opl2_clk),
		.cpu_ce      (cpu_ce),
		.periph_ce   (periph_ce),
		.opl2_ce     (opl2_ce)
	);

	audio_mixer_dac audio_mixer_dac_inst (
		.clk_chipset  (clk_chipset),
		.reset_wire   (sys_reset),
		.speaker      (speaker),
		.opl2_sample  (opl2_sample),
		.tandy_sample (tandy_sample),
		.dac_sample   (dac_sample),
		.audio_bit    (audio_bit)
	);

	// led runs even while the system is held
	activity_led activity_led_inst (
		.clk_chipset     (clk_chipset),
		.reset_wire      (reset_wire),
		.download_strobe (download_strobe),
		.led             (led)
	);

endmodule

//--- test/tb_pcxt_glue.sv
// run from the project root; every expected value comes from test/pcxt_golden.txt or the mixer rule
module tb_pcxt_glue;
	timeunit 1ns;
	timeprecision 100ps;

	// one golden line
	typedef struct packed {
		logic [31:0] id;
		logic [31:0] kind;
		logic [31:0] status;
		logic        spk;
		logic [15:0] opl2;
		logic [7:0]  tandy;
		logic        pb3;
		logic [31:0] e0;
		logic [31:0] e1;
	} vec_t;

	logic clk_chipset;
	logic reset_wire;
	logic [31:0] status;
	logic biu_done;
	logic opl2_clk;
	logic port_b_bit3;
	logic speaker;
	logic signed [15:0] opl2_sample;
	logic [7:0] tandy_sample;
	logic download_strobe;
	logic cpu_ce;
	logic periph_ce;
	logic opl2_ce;
	logic sys_reset;
	logic cpu_reset;
	logic tandy_mode;
	logic [3:0] dip_nibble;
	logic [15:0] dac_sample;
	logic audio_bit;
	logic led;

	vec_t vecs[$];
	int err_cnt = 0;
	int pass_cnt = 0;
	int fail_cnt = 0;
	integer seed = 19962;
	longint budget_ns = 0;

	pcxt_glue pcxt_glue_inst (.*);

	initial begin
		clk_chipset = 1'b0;
		forever #10 clk_chipset = ~clk_chipset;
	end

	//////////////////////////////
	// helpers
	//////////////////////////////
	function automatic bit near(input int got, input int want, input int tol);
		return (got >= want - tol) && (got <= want + tol);
	endfunction

	// sext(opl2) x4 + speaker x32768 + tandy x64, wrapped to 17 bits, then halved
	function automatic logic [15:0] mix_rule(input logic spk, input logic [15:0] opl,
		input logic [7:0] tnd);
		int sum;
		logic [16:0] wrapped;
		sum = $signed(opl) * 4 + (spk ? 32768 : 0) + int'(tnd) * 64;
		wrapped = sum[16:0];
		return wrapped[16:1];
	endfunction

	// rough cycles per test including reset and release
	function automatic int test_cycles(input int kind, input int e0);
		int c;
		c = 1105;
		case (kind)
			2: c += 1300;
			3: c += 300;
			5: c += 4110;
			7: c += 60;
			8: c += 1010;
			9: c += e0 * 2 + 2;
			default: c += 5;
		endcase
		return c;
	endfunction

	task automatic report_fail(input int id, input string msg);
		$display("FAIL t=%0t test %0d: %s", $time, id, msg);
		err_cnt++;
	endtask

	// 5 cycles of reset, then cycles until each reset falls
	task automatic apply_reset(input logic [31:0] st, output int sys_n, output int cpu_n);
		status = st;
		reset_wire = 1'b1;
		repeat (5) @(negedge clk_chipset);
		reset_wire = 1'b0;
		sys_n = 0;
		cpu_n = 0;
		while (sys_reset) begin
			@(negedge clk_chipset);
			sys_n++;
		end
		while (cpu_reset) begin
			@(negedge clk_chipset);
			cpu_n++;
		end
	endtask

	task automatic count_enables(input int cycles, output int n_cpu, output int n_per);
		n_cpu = 0;
		n_per = 0;
		repeat (cycles) begin
			@(negedge clk_chipset);
			if (cpu_ce) n_cpu++;
			if (periph_ce) n_per++;
		end
	endtask

	//////////////////////////////
	// per-behavior checks
	//////////////////////////////
	task automatic check_speed(input vec_t v);
		int n_cpu;
		int n_per;
		int n_after;
		// latch the new speed with one done pulse
		biu_done = 1'b1;
		@(negedge clk_chipset);
		biu_done = 1'b0;
		repeat (12) @(negedge clk_chipset);
		count_enables(120, n_cpu, n_per);
		if (!near(n_cpu, v.e0, 1))
			report_fail(v.id, $sformatf("cpu_ce count %0d, expected %0d", n_cpu, v.e0));
		if (n_per != v.e1)
			report_fail(v.id, $sformatf("periph_ce count %0d, expected %0d", n_per, v.e1));
		// other speed code without a done pulse
		status = v.status ^ 32'h0004_0000;
		repeat (12) @(negedge clk_chipset);
		count_enables(120, n_after, n_per);
		if (!near(n_after, v.e0, 1))
			report_fail(v.id, $sformatf("cpu_ce count %0d without biu_done, expected %0d",
				n_after, v.e0));
	endtask

	task automatic check_modulator(input vec_t v);
		int ones;
		speaker = v.spk;
		opl2_sample = v.opl2;
		tandy_sample = v.tandy;
		repeat (4) @(negedge clk_chipset);
		if (dac_sample !== v.e0[15:0])
			report_fail(v.id, $sformatf("dac_sample %h, expected %h", dac_sample, v.e0[15:0]));
		ones = 0;
		repeat (4096) begin
			@(negedge clk_chipset);
			if (audio_bit) ones++;
		end
		if (!near(ones, v.e1, 2))
			report_fail(v.id, $sformatf("audio_bit ones %0d, expected %0d", ones, v.e1));
	endtask

	task automatic check_opl2(input vec_t v);
		int n;
		n = 0;
		// opl2 clock at six chipset cycles per period
		for (int i = 0; i < 8; i++) begin
			for (int j = 0; j < 6; j++) begin
				opl2_clk = (j < 3);
				@(negedge clk_chipset);
				if (opl2_ce) n++;
			end
		end
		repeat (6) begin
			@(negedge clk_chipset);
			if (opl2_ce) n++;
		end
		if (n != v.e0)
			report_fail(v.id, $sformatf("opl2_ce pulses %0d, expected %0d", n, v.e0));
	endtask

	task automatic check_led(input vec_t v);
		int n;
		download_strobe = 1'b1;
		@(negedge clk_chipset);
		download_strobe = 1'b0;
		n = 0;
		if (!led)
			report_fail(v.id, "led low one cycle after download_strobe");
		while (led) begin
			n++;
			@(negedge clk_chipset);
		end
		if (!near(n, v.e0, 2))
			report_fail(v.id, $sformatf("led high %0d cycles, expected %0d", n, v.e0));
	endtask

	task automatic check_random_mix(input vec_t v);
		logic [31:0] r;
		logic [15:0] want;
		for (int i = 0; i < v.e0; i++) begin
			r = $random(seed);
			speaker = r[0];
			r = $random(seed);
			opl2_sample = r[15:0];
			r = $random(seed);
			tandy_sample = r[7:0];
			want = mix_rule(speaker, opl2_sample, tandy_sample);
			repeat (2) @(negedge clk_chipset);
			if (dac_sample !== want)
				report_fail(v.id, $sformatf("random vector %0d dac_sample %h, expected %h",
					i, dac_sample, want));
		end
	endtask

	//////////////////////////////
	// main sequence
	//////////////////////////////
	initial begin
		int fd;
		string line;
		int n_f;
		int f_id;
		int f_kind;
		int f_spk;
		int f_pb3;
		int f_e0;
		int f_e1;
		logic [31:0] f_status;
		logic [31:0] f_opl2;
		logic [31:0] f_tandy;
		vec_t v;
		longint total;
		int sys_n;
		int cpu_n;
		int errs_before;
		reset_wire = 1'b1;
		status = '0;
		biu_done = 1'b0;
		opl2_clk = 1'b0;
		port_b_bit3 = 1'b0;
		speaker = 1'b0;
		opl2_sample = '0;
		tandy_sample = '0;
		download_strobe = 1'b0;
		fd = $fopen("test/pcxt_golden.txt", "r");
		if (fd == 0) begin
			$display("could not open the golden file test/pcxt_golden.txt");
			err_cnt++;
		end else begin
			// column lines do not scan as nine fields
			while ($fgets(line, fd) != 0) begin
				n_f = $sscanf(line, "%d %d %h %d %h %h %d %d %d", f_id, f_kind, f_status,
					f_spk, f_opl2, f_tandy, f_pb3, f_e0, f_e1);
				if (n_f == 9) begin
					v.id = f_id;
					v.kind = f_kind;
					v.status = f_status;
					v.spk = f_spk[0];
					v.opl2 = f_opl2[15:0];
					v.tandy = f_tandy[7:0];
					v.pb3 = f_pb3[0];
					v.e0 = f_e0;
					v.e1 = f_e1;
					vecs.push_back(v);
				end
			end
			$fclose(fd);
		end
		if (vecs.size() == 0) begin
			$display("no test vectors were read from the golden file");
			err_cnt++;
		end
		total = 0;
		foreach (vecs[i]) total += test_cycles(vecs[i].kind, vecs[i].e0);
		// 20 ns per cycle plus 20 percent
		budget_ns = (total * 20 * 12) / 10 + 1000;
		foreach (vecs[i]) begin
			v = vecs[i];
			errs_before = err_cnt;
			apply_reset(v.status, sys_n, cpu_n);
			case (v.kind)
				1, 2: begin
					if (!near(sys_n, v.e0, 2))
						report_fail(v.id, $sformatf("sys_reset fell after %0d cycles, expected %0d",
							sys_n, v.e0));
					if (!near(cpu_n, v.e1, 2))
						report_fail(v.id, $sformatf("cpu_reset fell %0d cycles later, expected %0d",
							cpu_n, v.e1));
					if (tandy_mode !== v.status[3])
						report_fail(v.id, $sformatf("tandy_mode %b, expected %b", tandy_mode,
							v.status[3]));
					// model bit holds once the system runs
					status = v.status ^ 32'h0000_0008;
					repeat (2) @(negedge clk_chipset);
					if (tandy_mode !== v.status[3])
						report_fail(v.id, $sformatf("tandy_mode %b after release, expected %b",
							tandy_mode, v.status[3]));
				end
				3: check_speed(v);
				4: begin
					speaker = v.spk;
					opl2_sample = v.opl2;
					tandy_sample = v.tandy;
					repeat (2) @(negedge clk_chipset);
					if (dac_sample !== v.e0[15:0])
						report_fail(v.id, $sformatf("dac_sample %h, expected %h", dac_sample,
							v.e0[15:0]));
				end
				5: check_modulator(v);
				6: begin
					port_b_bit3 = v.pb3;
					repeat (2) @(negedge clk_chipset);
					if (dip_nibble !== v.e0[3:0])
						report_fail(v.id, $sformatf("dip_nibble %h, expected %h", dip_nibble,
							v.e0[3:0]));
				end
				7: check_opl2(v);
				8: check_led(v);
				9: check_random_mix(v);
				default: begin
					$display("test %0d has an unknown kind %0d in the golden file", v.id, v.kind);
					err_cnt++;
				end
			endcase
			if (err_cnt == errs_before) begin
				pass_cnt++;
				$display("test %0d kind %0d passed at %0t", v.id, v.kind, $time);
			end else begin
				fail_cnt++;
				$display("test %0d kind %0d failed at %0t", v.id, v.kind, $time);
			end
		end
		$display("summary: %0d tests passed, %0d tests failed, %0d errors", pass_cnt, fail_cnt,
			err_cnt);
		if (err_cnt == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

	// watchdog armed once the budget is known
	initial begin
		wait (budget_ns > 0);
		#(budget_ns);
		$display("timeout: the golden tests were still running after %0d ns", budget_ns);
		$display("TB FAILED");
		$finish;
	end

endmodule

//--- test/pcxt_golden.txt
# id kind status(hex) speaker opl2(hex) tandy(hex) portb3 exp0 exp1
# kinds: 1/2 reset release, 3 speed, 4 mixer, 5 modulator, 6 dip, 7 opl2, 8 led, 9 random mixer
1 1 00000088 0 0000 00 0 1024 44
2 1 00000080 0 0000 00 0 1024 44
3 2 00000008 0 0000 00 0 2304 44
4 3 00000080 0 0000 00 0 20 10
5 3 00020080 0 0000 00 0 30 10
6 3 00040080 0 0000 00 0 60 10
7 4 00000080 0 0000 00 0 0 0
8 4 00000080 1 0000 00 0 16384 0
9 4 00000080 0 1000 00 0 8192 0
10 4 00000080 0 f000 00 0 57344 0
11 4 00000080 0 0000 ff 0 8160 0
12 4 00000080 1 8000 80 0 20480 0
13 4 00000080 1 7fff ff 0 24542 0
14 9 00000080 0 0000 00 0 16 0
15 5 00000080 0 0000 00 0 0 2048
16 5 00000080 1 0000 00 0 16384 3072
17 5 00000080 0 f800 00 0 61440 1792
18 6 00000080 0 0000 00 0 13 0
19 6 00000080 0 0000 00 1 2 0
20 6 00000090 0 0000 00 0 13 0
21 6 00000090 0 0000 00 1 3 0
22 7 00000080 0 0000 00 0 8 0
23 8 00000080 0 0000 00 0 1000 0

//--- files.f
src/pcxt_pkg.sv
src/clock_enable_gen.sv
src/reset_sequencer.sv
src/audio_mixer_dac.sv
src/activity_led.sv
src/pcxt_glue.sv
test/tb_pcxt_glue.sv

//--- Makefile
# Verilator build and run for the PC/XT glue testbench

VERILATOR ?= verilator
TOP       ?= tb_pcxt_glue
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: sim clean

# build, run, then look for the pass line in the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^TB PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
